//--- function_generator.f
hdl/fg_pkg.sv
hdl/ram_write_if.sv
hdl/pattern_writer.sv
hdl/waveform_ram.sv
hdl/word_serializer.sv
hdl/function_generator.sv
verification/function_generator_tb.sv

//--- hdl/fg_pkg.sv
`default_nettype none

package fg_pkg;

	// one waveform word, also the serializer width
	typedef logic [7:0] word_t;

	// 16-bit fibonacci lfsr state
	typedef logic [15:0] lfsr_t;

	// built-in pattern selection
	typedef enum logic [1:0] {
		mode_ramp  = 2'd0,
		mode_bunch = 2'd1,
		mode_prbs  = 2'd2
	} fg_mode_t;

	// pattern writer handshake states
	typedef enum logic [1:0] {
		writer_idle,
		writer_drive,
		writer_wait_ack,
		writer_wait_release
	} writer_state_t;

	// serializer read handshake states
	typedef enum logic [1:0] {
		ser_idle,
		ser_fetch_first,
		ser_shifting,
		ser_release
	} serializer_state_t;

	// lfsr value at each start
	localparam lfsr_t prbs_seed = 16'hace1;

	// nonzero words of one bunch triplet
	localparam word_t bunch_head_word = 8'h80;
	localparam word_t bunch_tail_word = 8'h08;

endpackage

`default_nettype wire

//--- hdl/function_generator.sv
`default_nettype none

module function_generator #(
	parameter int ADDRESS_DEPTH = 8,
	parameter int BUNCH_TRAINS = 20
) (
	input wire clock,
	input wire reset,
	input wire start,
	input wire fg_pkg::fg_mode_t mode,
	input wire [ADDRESS_DEPTH-1:0] end_address,
	output logic loaded,
	output logic bit_out,
	output logic word_start
);

	// read link
	logic read_req;
	logic read_ack;
	fg_pkg::word_t read_data;

	// write link
	ram_write_if #(
		.ADDRESS_DEPTH(ADDRESS_DEPTH)
	) write_link ();

	pattern_writer #(
		.ADDRESS_DEPTH(ADDRESS_DEPTH),
		.BUNCH_TRAINS(BUNCH_TRAINS)
	) i_pattern_writer (
		.clock(clock),
		.reset(reset),
		.start(start),
		.mode(mode),
		.wr(write_link.writer),
		.loaded(loaded)
	);

	waveform_ram #(
		.ADDRESS_DEPTH(ADDRESS_DEPTH)
	) i_waveform_ram (
		.clock(clock),
		.reset(reset),
		.loaded(loaded),
		.end_address(end_address),
		.wr(write_link.ram),
		.read_req(read_req),
		.read_ack(read_ack),
		.read_data(read_data)
	);

	word_serializer i_word_serializer (
		.clock(clock),
		.reset(reset),
		.loaded(loaded),
		.read_ack(read_ack),
		.read_data(read_data),
		.read_req(read_req),
		.bit_out(bit_out),
		.word_start(word_start)
	);

endmodule

`default_nettype wire

//--- hdl/pattern_writer.sv
`default_nettype none

module pattern_writer #(
	parameter int ADDRESS_DEPTH = 8,
	parameter int BUNCH_TRAINS = 20
) (
	input wire clock,
	input wire reset,
	input wire start,
	input wire fg_pkg::fg_mode_t mode,
	ram_write_if.writer wr,
	output logic loaded
);

	typedef logic [ADDRESS_DEPTH-1:0] address_t;

	// words covered by the bunch triplets
	localparam int bunch_words = 3 * BUNCH_TRAINS;
	localparam address_t last_address = '1;

	fg_pkg::writer_state_t state;
	fg_pkg::fg_mode_t mode_q;
	address_t address_q;
	fg_pkg::lfsr_t lfsr;
	logic lfsr_feedback;
	logic [1:0] triplet_phase;
	fg_pkg::word_t pattern_word;
	logic launch;

	// taps 16 14 13 11
	assign lfsr_feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	// word for the current address in the latched mode
	always_comb begin
		pattern_word = '0;
		case (mode_q)
			fg_pkg::mode_ramp: begin
				pattern_word = fg_pkg::word_t'(address_q);
			end
			fg_pkg::mode_bunch: begin
				if (address_q < bunch_words) begin
					if (triplet_phase == 2'd0) begin
						pattern_word = fg_pkg::bunch_head_word;
					end else if (triplet_phase == 2'd1) begin
						pattern_word = fg_pkg::bunch_tail_word;
					end
				end
			end
			fg_pkg::mode_prbs: begin
				pattern_word = lfsr[7:0];
			end
			default: begin
				pattern_word = '0;
			end
		endcase
	end

	// first word from drive, later words straight from release
	assign launch = (state == fg_pkg::writer_drive) ||
		((state == fg_pkg::writer_wait_release) && !wr.ack && !loaded);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fg_pkg::writer_idle;
			wr.req <= 1'b0;
			loaded <= 1'b0;
			mode_q <= fg_pkg::mode_ramp;
			address_q <= '0;
			lfsr <= fg_pkg::prbs_seed;
			triplet_phase <= 2'd0;
		end else begin
			case (state)
				fg_pkg::writer_idle: begin
					// start only honoured here, so a start mid-fill is dropped
					if (start) begin
						loaded <= 1'b0;
						mode_q <= mode;
						address_q <= '0;
						lfsr <= fg_pkg::prbs_seed;
						triplet_phase <= 2'd0;
						state <= fg_pkg::writer_drive;
					end
				end
				fg_pkg::writer_drive: begin
					wr.req <= 1'b1;
					state <= fg_pkg::writer_wait_ack;
				end
				fg_pkg::writer_wait_ack: begin
					if (wr.ack) begin
						wr.req <= 1'b0;
						// step to the next word, data already held on the link
						address_q <= address_q + 1'b1;
						lfsr <= {lfsr[14:0], lfsr_feedback};
						if (triplet_phase == 2'd2) begin
							triplet_phase <= 2'd0;
						end else begin
							triplet_phase <= triplet_phase + 1'b1;
						end
						if (address_q == last_address) begin
							loaded <= 1'b1;
						end
						state <= fg_pkg::writer_wait_release;
					end
				end
				fg_pkg::writer_wait_release: begin
					if (!wr.ack) begin
						if (loaded) begin
							state <= fg_pkg::writer_idle;
						end else begin
							wr.req <= 1'b1;
							state <= fg_pkg::writer_wait_ack;
						end
					end
				end
				default: begin
					state <= fg_pkg::writer_idle;
				end
			endcase
		end
	end

	// address and data change only while req is low
	always_ff @(posedge clock) begin
		if (launch) begin
			wr.address <= address_q;
			wr.data <= pattern_word;
		end
	end

endmodule

`default_nettype wire

//--- hdl/ram_write_if.sv
`default_nettype none

// four-phase write link, writer side to ram side
interface ram_write_if #(
	parameter int ADDRESS_DEPTH = 8
);

	// raised by the writer with address and data stable
	logic req;
	logic [ADDRESS_DEPTH-1:0] address;
	fg_pkg::word_t data;
	// raised by the ram once the word is stored
	logic ack;

	modport writer (
		output req,
		output address,
		output data,
		input ack
	);

	modport ram (
		input req,
		input address,
		input data,
		output ack
	);

endinterface

`default_nettype wire

//--- hdl/waveform_ram.sv
`default_nettype none

module waveform_ram #(
	parameter int ADDRESS_DEPTH = 8
) (
	input wire clock,
	input wire reset,
	input wire loaded,
	input wire [ADDRESS_DEPTH-1:0] end_address,
	ram_write_if.ram wr,
	input wire read_req,
	output logic read_ack,
	output fg_pkg::word_t read_data
);

	typedef logic [ADDRESS_DEPTH-1:0] address_t;

	localparam int word_count = 2 ** ADDRESS_DEPTH;

	fg_pkg::word_t mem [word_count];
	address_t play_address;
	logic write_strobe;
	logic read_strobe;

	// new request, not yet answered
	assign write_strobe = wr.req && !wr.ack;
	// playback reads only once the fill is done
	assign read_strobe = loaded && read_req && !read_ack;

	// write side handshake
	always_ff @(posedge clock) begin
		if (reset) begin
			wr.ack <= 1'b0;
		end else if (write_strobe) begin
			wr.ack <= 1'b1;
		end else if (!wr.req) begin
			wr.ack <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (write_strobe) begin
			mem[wr.address] <= wr.data;
		end
	end

	// read side handshake and playback pointer
	always_ff @(posedge clock) begin
		if (reset || !loaded) begin
			read_ack <= 1'b0;
			play_address <= '0;
		end else if (read_strobe) begin
			read_ack <= 1'b1;
			// loop back to zero after the end address
			if (play_address == end_address) begin
				play_address <= '0;
			end else begin
				play_address <= play_address + 1'b1;
			end
		end else if (!read_req) begin
			read_ack <= 1'b0;
		end
	end

	// word registered together with ack
	always_ff @(posedge clock) begin
		if (read_strobe) begin
			read_data <= mem[play_address];
		end
	end

endmodule

`default_nettype wire

//--- hdl/word_serializer.sv
`default_nettype none

module word_serializer (
	input wire clock,
	input wire reset,
	input wire loaded,
	input wire read_ack,
	input wire fg_pkg::word_t read_data,
	output logic read_req,
	output logic bit_out,
	output logic word_start
);

	fg_pkg::serializer_state_t state;
	fg_pkg::word_t shift_q;
	fg_pkg::word_t next_word;
	logic next_valid;
	logic shift_valid;
	logic [2:0] bit_count;
	logic capture;
	logic load_next;

	// ram answered a pending fetch
	assign capture = read_req && read_ack &&
		((state == fg_pkg::ser_fetch_first) || (state == fg_pkg::ser_shifting));
	// prefetched word goes in right after the last bit
	assign load_next = next_valid && (!shift_valid || (bit_count == 3'd7));

	// msb first, silent while unloaded or starved
	assign bit_out = loaded && shift_valid && shift_q[7];
	assign word_start = loaded && shift_valid && (bit_count == 3'd0);

	always_ff @(posedge clock) begin
		if (reset || !loaded) begin
			state <= fg_pkg::ser_idle;
			read_req <= 1'b0;
			next_valid <= 1'b0;
			shift_valid <= 1'b0;
			bit_count <= 3'd0;
		end else begin
			case (state)
				fg_pkg::ser_idle: begin
					read_req <= 1'b1;
					state <= fg_pkg::ser_fetch_first;
				end
				fg_pkg::ser_fetch_first: begin
					if (read_ack) begin
						read_req <= 1'b0;
						state <= fg_pkg::ser_release;
					end
				end
				fg_pkg::ser_shifting: begin
					// fetch again once the held word was taken
					if (capture) begin
						read_req <= 1'b0;
						state <= fg_pkg::ser_release;
					end else if (!next_valid && !read_req) begin
						read_req <= 1'b1;
					end
				end
				fg_pkg::ser_release: begin
					if (!read_ack) begin
						state <= fg_pkg::ser_shifting;
					end
				end
				default: begin
					state <= fg_pkg::ser_idle;
				end
			endcase
			if (capture) begin
				next_valid <= 1'b1;
			end else if (load_next) begin
				next_valid <= 1'b0;
			end
			// bit counter, wraps 7 to 0
			if (load_next) begin
				shift_valid <= 1'b1;
				bit_count <= 3'd0;
			end else if (shift_valid) begin
				bit_count <= bit_count + 1'b1;
				if (bit_count == 3'd7) begin
					shift_valid <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (capture) begin
			next_word <= read_data;
		end
		if (load_next) begin
			shift_q <= next_word;
		end else if (shift_valid) begin
			shift_q <= {shift_q[6:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

//--- verification/function_generator_tb.sv
`default_nettype none

module function_generator_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int address_depth = 6;
	localparam int bunch_trains = 5;
	localparam int clock_period = 40;
	localparam int reset_cycles = 10;
	// 6 fills of 64 words at 4 cycles, 600 played words at 8 cycles, half again as margin
	localparam int watchdog_cycles = (6 * 64 * 4 + 3 * 200 * 8) * 3 / 2;

	logic clock = 1'b0;
	logic reset;
	logic start;
	fg_pkg::fg_mode_t mode;
	logic [address_depth-1:0] end_address;
	logic loaded;
	logic bit_out;
	logic word_start;

	// sampler and bookkeeping
	fg_pkg::fg_mode_t fill_mode;
	logic any_start;
	logic word_done;
	logic start_seen;
	logic [7:0] shreg;
	logic [7:0] got_word;
	logic [7:0] exp_word;
	int bit_index;
	int play_index;
	int word_count;
	int since_loaded;
	int gap;
	int gap_at_start;
	int words_checked;
	int error_count;
	int errors_before;
	int test_count;
	integer seed;
	string test_name;

	function_generator #(
		.ADDRESS_DEPTH(address_depth),
		.BUNCH_TRAINS(bunch_trains)
	) i_dut (
		.clock(clock),
		.reset(reset),
		.start(start),
		.mode(mode),
		.end_address(end_address),
		.loaded(loaded),
		.bit_out(bit_out),
		.word_start(word_start)
	);

	always #(clock_period / 2) clock = ~clock;

	// reference word for one ram address
	function automatic logic [7:0] expected_word(input fg_pkg::fg_mode_t m, input int a);
		logic [15:0] lfsr;
		int i;
		lfsr = 16'hace1;
		case (m)
			fg_pkg::mode_ramp: begin
				return a[7:0];
			end
			fg_pkg::mode_bunch: begin
				if (a >= 3 * bunch_trains) begin
					return 8'h00;
				end
				// head, tail, empty slot
				case (a % 3)
					0: return 8'h80;
					1: return 8'h08;
					default: return 8'h00;
				endcase
			end
			default: begin
				// fibonacci taps 16 14 13 11, one step per earlier address
				for (i = 0; i < a; i++) begin
					lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
				end
				return lfsr[7:0];
			end
		endcase
	endfunction

	function automatic logic [address_depth-1:0] random_end();
		return 8 + ($unsigned($random(seed)) % 56);
	endfunction

	// outputs settle after the rising edge, so bits are taken on the falling edge
	always @(negedge clock) begin
		word_done = 1'b0;
		start_seen = 1'b0;
		if (reset || !loaded) begin
			bit_index = 0;
			play_index = 0;
			word_count = 0;
			since_loaded = 0;
			gap = 0;
		end else begin
			since_loaded = since_loaded + 1;
			gap = gap + 1;
			if (word_start) begin
				start_seen = 1'b1;
				gap_at_start = gap;
				gap = 0;
				word_count = word_count + 1;
				shreg = {7'b0, bit_out};
				bit_index = 1;
			end else if (bit_index > 0) begin
				shreg = {shreg[6:0], bit_out};
				bit_index = bit_index + 1;
			end
			if (bit_index == 8) begin
				got_word = shreg;
				exp_word = expected_word(fill_mode, play_index);
				word_done = 1'b1;
				words_checked = words_checked + 1;
				bit_index = 0;
				// playback loops back after the end address
				play_index = (play_index == end_address) ? 0 : play_index + 1;
			end
		end
	end

	word_check: assert property (@(posedge clock) disable iff (reset)
		word_done |-> got_word == exp_word)
	else begin
		error_count++;
		$display("ERROR %s: expected %02h, actual %02h", test_name, exp_word, got_word);
	end

	word_spacing: assert property (@(posedge clock) disable iff (reset)
		start_seen && word_count > 1 |-> gap_at_start == 8)
	else begin
		error_count++;
		$display("test %s: words came %0d cycles apart instead of 8", test_name, gap_at_start);
	end

	first_latency: assert property (@(posedge clock) disable iff (reset)
		loaded && word_count == 0 |-> since_loaded <= 10)
	else begin
		error_count++;
		$display("test %s: no word within ten cycles of loaded", test_name);
	end

	quiet_unloaded: assert property (@(posedge clock) disable iff (reset)
		!loaded |-> !bit_out && !word_start)
	else begin
		error_count++;
		$display("test %s: output active while not loaded", test_name);
	end

	idle_after_reset: assert property (@(posedge clock) disable iff (reset)
		!any_start |-> !loaded)
	else begin
		error_count++;
		$display("test %s: loaded rose without a start pulse", test_name);
	end

	task automatic begin_test(input string name);
		test_name = name;
		errors_before = error_count;
		test_count++;
	endtask

	task automatic end_test();
		$display("test %s: %0d errors", test_name, error_count - errors_before);
	endtask

	// one-cycle start pulse, the fill mode is taken as accepted
	task automatic start_fill(input fg_pkg::fg_mode_t m, input logic [address_depth-1:0] e);
		mode = m;
		end_address = e;
		start = 1'b1;
		any_start = 1'b1;
		@(posedge clock);
		#2;
		start = 1'b0;
		fill_mode = m;
	endtask

	// start pulse the writer should drop
	task automatic ignored_start(input fg_pkg::fg_mode_t m);
		mode = m;
		start = 1'b1;
		@(posedge clock);
		#2;
		start = 1'b0;
	endtask

	task automatic wait_loaded();
		wait (loaded === 1'b1);
		@(posedge clock);
		#2;
	endtask

	task automatic watch_words(input int n);
		int target;
		target = words_checked + n;
		wait (words_checked >= target);
		@(posedge clock);
		#2;
	endtask

	initial begin
		seed = 85586;
		error_count = 0;
		words_checked = 0;
		test_count = 0;
		reset = 1'b1;
		start = 1'b0;
		mode = fg_pkg::mode_ramp;
		end_address = '0;
		any_start = 1'b0;
		fill_mode = fg_pkg::mode_ramp;
		repeat (reset_cycles) @(posedge clock);
		#2;
		reset = 1'b0;

		begin_test("reset");
		repeat (20) @(posedge clock);
		#2;
		end_test();

		begin_test("ramp");
		start_fill(fg_pkg::mode_ramp, random_end());
		wait_loaded();
		watch_words(end_address + 10);
		end_test();

		begin_test("bunch");
		start_fill(fg_pkg::mode_bunch, random_end());
		wait_loaded();
		watch_words(end_address + 10);
		end_test();

		// second fill in the same mode restarts the lfsr
		begin_test("prbs");
		start_fill(fg_pkg::mode_prbs, random_end());
		wait_loaded();
		watch_words(end_address + 5);
		start_fill(fg_pkg::mode_prbs, end_address);
		wait_loaded();
		watch_words(end_address + 5);
		end_test();

		begin_test("restart");
		start_fill(fg_pkg::mode_bunch, random_end());
		assert (loaded === 1'b0) else begin
			error_count++;
			$display("test %s: loaded stayed high after start during playback", test_name);
		end
		wait_loaded();
		watch_words(end_address + 5);
		end_test();

		// start in the middle of a fill
		begin_test("busy start");
		start_fill(fg_pkg::mode_ramp, random_end());
		repeat (30) @(posedge clock);
		#2;
		ignored_start(fg_pkg::mode_prbs);
		wait_loaded();
		watch_words(end_address + 5);
		end_test();

		$display("%0d tests, %0d words checked, %0d errors", test_count, words_checked,
			error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// hang guard
	initial begin
		#(watchdog_cycles * clock_period);
		$display("run stopped by the watchdog in test %s", test_name);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
